//--- verilog/wdc_defs.svh
////////////////////////////////////////////////////////////////////////////
// size macros for the acquisition core
// sample and LTC widths, capture window, FIFO depths
////////////////////////////////////////////////////////////////////////////
`ifndef WDC_DEFS_SVH
`define WDC_DEFS_SVH

// digitizer channels
`define WDC_N_CHAN      2
// adc sample and local time counter widths
`define WDC_SAMPLE_W    12
`define WDC_LTC_W       48

// capture window: pretrigger part, then trigger sample plus the rest
`define WDC_PRE_LEN     4
`define WDC_POST_LEN    12
`define WDC_WIN_LEN     (`WDC_PRE_LEN + `WDC_POST_LEN)

// per channel event storage, room for 4 full events
`define WDC_SAMP_DEPTH  64
`define WDC_HDR_DEPTH   4

`endif

//--- verilog/wdc_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared packed types of the acquisition core
// samples, time counts, trigger config, event headers, output words
////////////////////////////////////////////////////////////////////////////
`include "wdc_defs.svh"

package wdc_pkg;

  typedef logic [`WDC_SAMPLE_W-1:0] sample_t;
  typedef logic [`WDC_LTC_W-1:0] ltc_t;

  // per channel trigger settings
  typedef struct packed {
    sample_t thresh;
    logic    gt;
    logic    lt;
    logic    thresh_en;
    // accept the other channel's trigger
    logic    link_en;
  } trig_conf_t;

  // registered sample plus crossing flag
  typedef struct packed {
    sample_t samp;
    logic    trig;
  } trig_word_t;

  // event header, link set when only the other channel fired
  typedef struct packed {
    logic chan;
    logic link;
    ltc_t ltc;
  } hdr_t;

  // payload is the ltc on sop, else a zero extended sample
  typedef struct packed {
    logic sop;
    logic eop;
    logic chan;
    logic link;
    ltc_t payload;
  } rd_word_t;

endpackage

//--- verilog/wvb_fifo.sv
////////////////////////////////////////////////////////////////////////////
// show-ahead synchronous FIFO, payload type set by parameter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wvb_fifo #(
  parameter type T = logic,
  // power of two, pointers wrap on their own
  parameter int DEPTH = 4
) (
  input  logic                       lclk,
  input  logic                       lclk_rst,
  input  logic                       i_wr,
  input  T                           i_data,
  input  logic                       i_pop,
  output T                           o_data,
  output logic                       o_empty,
  output logic [$clog2(DEPTH+1)-1:0] o_count
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  T mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic wr_ok;
  logic pop_ok;

  // writes to a full buffer are dropped, pops of an empty one too
  assign wr_ok  = i_wr && (count != CW'(DEPTH));
  assign pop_ok = i_pop && (count != '0);

  always_ff @(posedge lclk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CW'(wr_ok) - CW'(pop_ok);
    end
  end

  // head visible while not empty
  assign o_data  = mem[rd_ptr];
  assign o_empty = (count == '0);
  assign o_count = count;

endmodule

//--- verilog/thresh_trigger.sv
////////////////////////////////////////////////////////////////////////////
// threshold trigger for one channel
// registers the sample, flags gt or lt threshold crossings
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module thresh_trigger (
  input  logic                lclk,
  input  logic                lclk_rst,
  input  wdc_pkg::sample_t    i_samp,
  input  wdc_pkg::trig_conf_t i_conf,
  output wdc_pkg::trig_word_t o_word
);

  import wdc_pkg::*;

  sample_t samp_q;
  logic trig_q;
  logic above;
  logic below;
  // comparison results of the previous sample
  logic above_q;
  logic below_q;
  logic gt_cross;
  logic lt_cross;

  // compare on the raw input, result lines up with samp_q
  assign above = i_samp > i_conf.thresh;
  assign below = i_samp < i_conf.thresh;

  // edge only, a level above threshold fires once
  assign gt_cross = i_conf.gt && above && !above_q;
  assign lt_cross = i_conf.lt && below && !below_q;

  always_ff @(posedge lclk) begin
    samp_q <= i_samp;
  end

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      trig_q  <= 1'b0;
      // start as if already crossed, no trigger on the first sample
      above_q <= 1'b1;
      below_q <= 1'b1;
    end else begin
      trig_q  <= i_conf.thresh_en && (gt_cross || lt_cross);
      above_q <= above;
      below_q <= below;
    end
  end

  assign o_word = '{samp: samp_q, trig: trig_q};

endmodule

//--- verilog/wvf_capture.sv
////////////////////////////////////////////////////////////////////////////
// waveform capture for one channel
// pretrigger delay line, window counter, header and sample FIFOs
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wdc_defs.svh"

module wvf_capture #(
  parameter int CHAN = 0
) (
  input  logic                lclk,
  input  logic                lclk_rst,
  input  wdc_pkg::trig_word_t i_word,
  input  logic                i_link_trig,
  input  wdc_pkg::ltc_t       i_ltc,
  input  logic                i_hdr_pop,
  input  logic                i_samp_pop,
  output wdc_pkg::hdr_t       o_hdr,
  output logic                o_hdr_empty,
  output wdc_pkg::sample_t    o_samp,
  output logic                o_overflow
);

  import wdc_pkg::*;

  localparam int HC_W = $clog2(`WDC_HDR_DEPTH + 1);
  localparam int SC_W = $clog2(`WDC_SAMP_DEPTH + 1);
  localparam int WC_W = $clog2(`WDC_WIN_LEN);

  // delay line, dly[PRE-1] is the word from PRE cycles back
  sample_t dly [`WDC_PRE_LEN];
  logic busy;
  logic [WC_W-1:0] cnt;
  logic start_req;
  logic room;
  logic start;
  hdr_t hdr_in;
  logic [HC_W-1:0] hdr_count;
  logic [SC_W-1:0] samp_count;

  always_ff @(posedge lclk) begin
    dly[0] <= i_word.samp;
    for (int k = 1; k < `WDC_PRE_LEN; k++) begin
      dly[k] <= dly[k-1];
    end
  end

  // own or linked trigger while idle
  assign start_req = !busy && (i_word.trig || i_link_trig);
  // a whole event must fit, never a partial window
  assign room = (hdr_count < HC_W'(`WDC_HDR_DEPTH)) &&
                (samp_count <= SC_W'(`WDC_SAMP_DEPTH - `WDC_WIN_LEN));
  assign start = start_req && room;

  // ltc of the trigger word, link only if own trigger absent
  assign hdr_in = '{chan: 1'(CHAN), link: !i_word.trig, ltc: i_ltc};

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      busy       <= 1'b0;
      cnt        <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        cnt  <= WC_W'(1);
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == WC_W'(`WDC_WIN_LEN - 1)) begin
          busy <= 1'b0;
        end
      end
      // sticky until reset
      if (start_req && !room) begin
        o_overflow <= 1'b1;
      end
    end
  end

  // first sample goes in on the start cycle itself
  wvb_fifo #(.T(sample_t), .DEPTH(`WDC_SAMP_DEPTH)) u_samp_fifo (
    .lclk     (lclk),
    .lclk_rst (lclk_rst),
    .i_wr     (start || busy),
    .i_data   (dly[`WDC_PRE_LEN-1]),
    .i_pop    (i_samp_pop),
    .o_data   (o_samp),
    .o_empty  (),
    .o_count  (samp_count)
  );

  wvb_fifo #(.T(hdr_t), .DEPTH(`WDC_HDR_DEPTH)) u_hdr_fifo (
    .lclk     (lclk),
    .lclk_rst (lclk_rst),
    .i_wr     (start),
    .i_data   (hdr_in),
    .i_pop    (i_hdr_pop),
    .o_data   (o_hdr),
    .o_empty  (o_hdr_empty),
    .o_count  (hdr_count)
  );

endmodule

//--- verilog/wvb_readout.sv
////////////////////////////////////////////////////////////////////////////
// round-robin event reader
// header word then window samples, one word per cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wdc_defs.svh"

module wvb_readout (
  input  logic                                lclk,
  input  logic                                lclk_rst,
  input  logic                                i_rd_en,
  input  wdc_pkg::hdr_t    [`WDC_N_CHAN-1:0]  i_hdr,
  input  logic             [`WDC_N_CHAN-1:0]  i_hdr_empty,
  input  wdc_pkg::sample_t [`WDC_N_CHAN-1:0]  i_samp,
  output logic             [`WDC_N_CHAN-1:0]  o_hdr_pop,
  output logic             [`WDC_N_CHAN-1:0]  o_samp_pop,
  output logic                                o_rd_valid,
  output wdc_pkg::rd_word_t                   o_rd_word
);

  import wdc_pkg::*;

  localparam int CH_W = $clog2(`WDC_N_CHAN);
  localparam int EC_W = $clog2(`WDC_WIN_LEN + 1);

  logic busy;
  // word index in the event, 0 is the header
  logic [EC_W-1:0] cnt;
  logic [CH_W-1:0] cur;
  logic [CH_W-1:0] last;
  logic [CH_W-1:0] cand;
  logic [CH_W-1:0] pick;
  logic found;
  // header fields held for the sample words
  logic ev_chan;
  logic ev_link;

  // search starts at the channel after the last one served
  always_comb begin
    pick  = last;
    found = 1'b0;
    cand  = last;
    for (int k = 1; k <= `WDC_N_CHAN; k++) begin
      cand = CH_W'((int'(last) + k) % `WDC_N_CHAN);
      if (!found && !i_hdr_empty[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // pop the head being registered this cycle
  always_comb begin
    o_hdr_pop  = '0;
    o_samp_pop = '0;
    if (busy) begin
      if (cnt == '0) begin
        o_hdr_pop[cur] = 1'b1;
      end else begin
        o_samp_pop[cur] = 1'b1;
      end
    end
  end

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      busy       <= 1'b0;
      cnt        <= '0;
      cur        <= '0;
      // reset to the last channel so channel 0 goes first
      last       <= CH_W'(`WDC_N_CHAN - 1);
      o_rd_valid <= 1'b0;
      o_rd_word  <= '0;
    end else begin
      o_rd_valid    <= 1'b0;
      o_rd_word.sop <= 1'b0;
      o_rd_word.eop <= 1'b0;
      if (!busy) begin
        if (i_rd_en && found) begin
          busy <= 1'b1;
          cnt  <= '0;
          cur  <= pick;
          last <= pick;
        end
      end else begin
        o_rd_valid <= 1'b1;
        cnt        <= cnt + 1'b1;
        if (cnt == '0) begin
          o_rd_word <= '{sop: 1'b1, eop: 1'b0, chan: i_hdr[cur].chan,
                         link: i_hdr[cur].link, payload: i_hdr[cur].ltc};
          ev_chan   <= i_hdr[cur].chan;
          ev_link   <= i_hdr[cur].link;
        end else begin
          o_rd_word <= '{sop: 1'b0, eop: (cnt == EC_W'(`WDC_WIN_LEN)),
                         chan: ev_chan, link: ev_link,
                         payload: {{(`WDC_LTC_W - `WDC_SAMPLE_W){1'b0}}, i_samp[cur]}};
        end
        // last sample word, back to idle
        if (cnt == EC_W'(`WDC_WIN_LEN)) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

//--- verilog/wdc_acq_top.sv
////////////////////////////////////////////////////////////////////////////
// acquisition core top, two channel digitizer
// ltc counter, triggers, captures, link wiring, event reader
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wdc_defs.svh"

module wdc_acq_top (
  input  logic                                 lclk,
  input  logic                                 lclk_rst,
  input  wdc_pkg::sample_t    [`WDC_N_CHAN-1:0] i_adc_samp,
  input  wdc_pkg::trig_conf_t [`WDC_N_CHAN-1:0] i_trig_conf,
  input  logic                                 i_rd_en,
  output logic                                 o_rd_valid,
  output wdc_pkg::rd_word_t                    o_rd_word,
  output logic                [`WDC_N_CHAN-1:0] o_overflow
);

  import wdc_pkg::*;

  ltc_t ltc;
  trig_word_t [`WDC_N_CHAN-1:0] trig_word;
  logic       [`WDC_N_CHAN-1:0] link_trig;
  hdr_t       [`WDC_N_CHAN-1:0] hdr;
  logic       [`WDC_N_CHAN-1:0] hdr_empty;
  sample_t    [`WDC_N_CHAN-1:0] samp;
  logic       [`WDC_N_CHAN-1:0] hdr_pop;
  logic       [`WDC_N_CHAN-1:0] samp_pop;

  // local time counter, 0 on the first cycle out of reset
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      ltc <= '0;
    end else begin
      ltc <= ltc + 1'b1;
    end
  end

  for (genvar c = 0; c < `WDC_N_CHAN; c++) begin : g_chan
    thresh_trigger u_trig (
      .lclk     (lclk),
      .lclk_rst (lclk_rst),
      .i_samp   (i_adc_samp[c]),
      .i_conf   (i_trig_conf[c]),
      .o_word   (trig_word[c])
    );

    // other channel's crossing, gated by this channel's link enable
    assign link_trig[c] = trig_word[(c + 1) % `WDC_N_CHAN].trig && i_trig_conf[c].link_en;

    wvf_capture #(.CHAN(c)) u_capture (
      .lclk        (lclk),
      .lclk_rst    (lclk_rst),
      .i_word      (trig_word[c]),
      .i_link_trig (link_trig[c]),
      .i_ltc       (ltc),
      .i_hdr_pop   (hdr_pop[c]),
      .i_samp_pop  (samp_pop[c]),
      .o_hdr       (hdr[c]),
      .o_hdr_empty (hdr_empty[c]),
      .o_samp      (samp[c]),
      .o_overflow  (o_overflow[c])
    );
  end

  wvb_readout u_readout (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_rd_en     (i_rd_en),
    .i_hdr       (hdr),
    .i_hdr_empty (hdr_empty),
    .i_samp      (samp),
    .o_hdr_pop   (hdr_pop),
    .o_samp_pop  (samp_pop),
    .o_rd_valid  (o_rd_valid),
    .o_rd_word   (o_rd_word)
  );

endmodule

//--- verif/wdc_acq_sva.sv
////////////////////////////////////////////////////////////////////////////
// assertions on the output word stream and the overflow flags
// bound into the acquisition top
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wdc_defs.svh"

module wdc_acq_sva (
  input logic                   lclk,
  input logic                   lclk_rst,
  input logic                   o_rd_valid,
  input wdc_pkg::rd_word_t      o_rd_word,
  input logic [`WDC_N_CHAN-1:0] o_overflow
);

  import wdc_pkg::*;

  localparam int WL_W = $clog2(`WDC_WIN_LEN + 1);

  // sample words still owed by the current event
  logic [WL_W-1:0] words_left;

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      words_left <= '0;
    end else if (o_rd_valid && o_rd_word.sop) begin
      words_left <= WL_W'(`WDC_WIN_LEN);
    end else if (words_left != '0) begin
      words_left <= words_left - 1'b1;
    end
  end

  a_idle_in_reset: assert property (@(posedge lclk) lclk_rst |=> !o_rd_valid)
    else $error("output valid while reset was held");

  // every owed word present, eop only on the last one
  a_frame: assert property (@(posedge lclk) disable iff (lclk_rst)
    (words_left != '0) |-> (o_rd_valid && !o_rd_word.sop &&
                           (o_rd_word.eop == (words_left == WL_W'(1)))))
    else $error("event frame broken, sample word missing or eop misplaced");

  // outside a frame a valid word must open one
  a_no_stray_word: assert property (@(posedge lclk) disable iff (lclk_rst)
    (words_left == '0 && o_rd_valid) |-> o_rd_word.sop)
    else $error("valid word outside an event frame");

  a_overflow_sticky: assert property (@(posedge lclk) disable iff (lclk_rst)
    (($past(o_overflow) & ~o_overflow) == '0))
    else $error("overflow flag fell without reset");

endmodule

bind wdc_acq_top wdc_acq_sva u_sva (
  .lclk       (lclk),
  .lclk_rst   (lclk_rst),
  .o_rd_valid (o_rd_valid),
  .o_rd_word  (o_rd_word),
  .o_overflow (o_overflow)
);

//--- verif/wdc_acq_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the two channel acquisition core
// clock, reset, sample streams, directed tests, compare tasks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "wdc_defs.svh"

module wdc_acq_tb;

  import wdc_pkg::*;

  localparam int HIST = 4096;
  localparam int EV_TIMEOUT = 400;
  localparam int GAP = 30;
  localparam logic [1:0] SPIKE_HI = 2'd1;
  localparam logic [1:0] SPIKE_LO = 2'd2;

  logic lclk = 1'b0;
  logic lclk_rst = 1'b1;
  sample_t [`WDC_N_CHAN-1:0] i_adc_samp = '0;
  trig_conf_t [`WDC_N_CHAN-1:0] i_trig_conf;
  logic i_rd_en;
  logic o_rd_valid;
  rd_word_t o_rd_word;
  logic [`WDC_N_CHAN-1:0] o_overflow;

  integer seed = 32'h076f55f0;
  int cyc = 0;
  // last edge with reset high, ltc reads 0 in the cycle after it
  int rst_end = 8;
  // driven samples per channel, indexed by drive cycle
  sample_t hist [`WDC_N_CHAN][HIST];
  logic [1:0] spike_map [`WDC_N_CHAN][HIST];

  wdc_acq_top u_wdc_acq_top (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_adc_samp  (i_adc_samp),
    .i_trig_conf (i_trig_conf),
    .i_rd_en     (i_rd_en),
    .o_rd_valid  (o_rd_valid),
    .o_rd_word   (o_rd_word),
    .o_overflow  (o_overflow)
  );

  always #10 lclk = ~lclk;

  // ramp plus noise, well between the lt and gt thresholds
  always @(posedge lclk) begin
    sample_t s;
    #1;
    cyc = cyc + 1;
    lclk_rst = (cyc < rst_end);
    for (int c = 0; c < `WDC_N_CHAN; c++) begin
      s = 12'h100 + sample_t'(cyc % 256) + sample_t'($random(seed) & 15);
      if (spike_map[c][cyc % HIST] == SPIKE_HI) begin
        s = 12'hc00 + sample_t'(cyc % 256);
      end else if (spike_map[c][cyc % HIST] == SPIKE_LO) begin
        s = 12'h010 + sample_t'(cyc % 32);
      end
      i_adc_samp[c] = s;
      hist[c][cyc % HIST] = s;
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_hdr(input rd_word_t got, input rd_word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERR o_rd_word header got %h exp %h", got, exp));
    end
  endtask

  // whole payload, sample zero extended
  task automatic check_samp(input rd_word_t got, input sample_t exp, input int idx);
    if (got.payload !== ltc_t'(exp)) begin
      fail_now($sformatf("ERR o_rd_word.payload sample %0d got %h exp %h",
                         idx, got.payload, ltc_t'(exp)));
    end
  endtask

  task automatic check_flags(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic check_ltc(input string name, input ltc_t got, input ltc_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic wait_reset_done();
    int t;
    t = 0;
    @(negedge lclk);
    while (lclk_rst) begin
      if (t == 40) begin
        fail_now("reset was never released");
      end
      t++;
      @(negedge lclk);
    end
  endtask

  // eight more reset edges starting at the next one
  task automatic restart_dut();
    @(negedge lclk);
    rst_end = cyc + 9;
    @(negedge lclk);
    wait_reset_done();
  endtask

  task automatic set_conf(input int ch, input sample_t thr, input logic is_gt,
                          input logic is_lt, input logic en, input logic link);
    @(posedge lclk);
    #1;
    i_trig_conf[ch] = '{thresh: thr, gt: is_gt, lt: is_lt, thresh_en: en, link_en: link};
  endtask

  task automatic set_rd_en(input logic v);
    @(posedge lclk);
    #1;
    i_rd_en = v;
  endtask

  task automatic mark_cross(input int ch, input logic [1:0] kind, input int at);
    spike_map[ch][at % HIST] = kind;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge lclk);
  endtask

  // header then the window, crossing sample at position PRE_LEN
  task automatic read_event(input int ch, input logic link, input int at, output ltc_t got_ltc);
    rd_word_t exp_w;
    int t;
    t = 0;
    @(negedge lclk);
    while (!(o_rd_valid && o_rd_word.sop)) begin
      if (t == EV_TIMEOUT) begin
        fail_now("no event header arrived in time");
      end
      t++;
      @(negedge lclk);
    end
    exp_w = '{sop: 1'b1, eop: 1'b0, chan: 1'(ch), link: link,
              payload: ltc_t'(at + 1 - rst_end)};
    check_hdr(o_rd_word, exp_w);
    got_ltc = o_rd_word.payload;
    for (int k = 0; k < `WDC_WIN_LEN; k++) begin
      @(negedge lclk);
      if (!o_rd_valid) begin
        fail_now("event ended before its last sample word");
      end
      check_flags("o_rd_word sop eop chan link",
                  {o_rd_word.sop, o_rd_word.eop, o_rd_word.chan, o_rd_word.link},
                  {1'b0, k == `WDC_WIN_LEN - 1, 1'(ch), link});
      check_samp(o_rd_word, hist[ch][(at - `WDC_PRE_LEN + k) % HIST], k);
    end
  endtask

  task automatic expect_quiet(input int n);
    for (int k = 0; k < n; k++) begin
      @(negedge lclk);
      if (o_rd_valid) begin
        fail_now("an event was read out where no trigger should have fired");
      end
    end
  endtask

  task automatic test_gt_single();
    int at;
    ltc_t l0;
    set_conf(0, 12'h800, 1'b1, 1'b0, 1'b1, 1'b0);
    @(negedge lclk);
    at = cyc + 4;
    mark_cross(0, SPIKE_HI, at);
    read_event(0, 1'b0, at, l0);
  endtask

  task automatic test_lt_and_disable();
    int at;
    ltc_t l0;
    set_conf(1, 12'h040, 1'b0, 1'b1, 1'b1, 1'b0);
    @(negedge lclk);
    at = cyc + 4;
    mark_cross(1, SPIKE_LO, at);
    read_event(1, 1'b0, at, l0);
    // same crossing with the trigger switched off
    set_conf(1, 12'h040, 1'b0, 1'b1, 1'b0, 1'b0);
    @(negedge lclk);
    mark_cross(1, SPIKE_LO, cyc + 4);
    expect_quiet(80);
  endtask

  task automatic test_link();
    int at;
    ltc_t l0;
    ltc_t l1;
    set_conf(1, 12'h800, 1'b1, 1'b0, 1'b1, 1'b1);
    @(negedge lclk);
    at = cyc + 4;
    mark_cross(0, SPIKE_HI, at);
    read_event(0, 1'b0, at, l0);
    read_event(1, 1'b1, at, l1);
    check_ltc("linked header ltc", l1, l0);
    set_conf(1, 12'h800, 1'b1, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic test_ltc_spacing();
    int at_a;
    int at_b;
    ltc_t la;
    ltc_t lb;
    @(negedge lclk);
    at_a = cyc + 4;
    at_b = at_a + GAP;
    mark_cross(0, SPIKE_HI, at_a);
    mark_cross(0, SPIKE_HI, at_b);
    read_event(0, 1'b0, at_a, la);
    read_event(0, 1'b0, at_b, lb);
    check_ltc("ltc spacing", lb - la, ltc_t'(GAP));
  endtask

  // four events fill channel 0, the fifth is refused
  task automatic test_overflow();
    int at [6];
    ltc_t l0;
    set_rd_en(1'b0);
    restart_dut();
    check_flags("o_overflow after reset", 4'(o_overflow), 4'b0000);
    @(negedge lclk);
    for (int k = 0; k < 6; k++) begin
      at[k] = cyc + 4 + 24 * k;
      mark_cross((k == 5) ? 1 : 0, SPIKE_HI, at[k]);
    end
    wait_cycles(24 * 5 + 30);
    check_flags("o_overflow", 4'(o_overflow), 4'b0001);
    set_rd_en(1'b1);
    read_event(0, 1'b0, at[0], l0);
    read_event(1, 1'b0, at[5], l0);
    read_event(0, 1'b0, at[1], l0);
    read_event(0, 1'b0, at[2], l0);
    read_event(0, 1'b0, at[3], l0);
    expect_quiet(60);
  endtask

  initial begin
    i_rd_en = 1'b0;
    for (int c = 0; c < `WDC_N_CHAN; c++) begin
      i_trig_conf[c] = '{thresh: 12'h800, gt: 1'b1, lt: 1'b0, thresh_en: 1'b0, link_en: 1'b0};
      for (int a = 0; a < HIST; a++) begin
        spike_map[c][a] = 2'd0;
      end
    end
    wait_reset_done();
    check_flags("o_overflow after reset", 4'(o_overflow), 4'b0000);
    set_rd_en(1'b1);
    test_gt_single();
    test_lt_and_disable();
    test_link();
    test_ltc_spacing();
    test_overflow();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- files.f
+incdir+verilog
verilog/wdc_pkg.sv
verilog/wvb_fifo.sv
verilog/thresh_trigger.sv
verilog/wvf_capture.sv
verilog/wvb_readout.sv
verilog/wdc_acq_top.sv
verif/wdc_acq_sva.sv
verif/wdc_acq_tb.sv

//--- Makefile
TOP := wdc_acq_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
